// File: design/audio_pkg.sv
////////////////////////////////////////
// Shared audio sample and mix types
// Master boost mode encoding
// Two-slope compressor constants
////////////////////////////////////////

`default_nettype none

package audio_pkg;

	// Signed sample at every channel input and output
	typedef logic signed [15:0] sample_t;

	// Stereo accumulator, two bits of headroom over a sample
	typedef logic signed [17:0] wide_t;

	// Master boost; the unused code 3 acts as BOOST_X4
	typedef enum logic [1:0] {
		BOOST_OFF = 2'd0,
		BOOST_X2  = 2'd1,
		BOOST_X4  = 2'd2
	} boost_t;

	// Input sample set to output word
	localparam int MIX_LATENCY = 4;

	////////////////////////////////////////
	// Compressor, 2x mode
	////////////////////////////////////////

	// Slope divider above the knee
	localparam int COMP_RATIO_X2 = 4;
	// Linear gain below the knee
	localparam int COMP_GAIN_X2 = 2;
	// Knee magnitude of the 16-bit word
	localparam int COMP_KNEE_X2 = 14044;
	// Output level reached at the knee
	localparam int COMP_BASE_X2 = COMP_KNEE_X2 * COMP_GAIN_X2;

	////////////////////////////////////////
	// Compressor, 4x mode
	////////////////////////////////////////

	localparam int COMP_RATIO_X4 = 8;
	localparam int COMP_GAIN_X4 = 4;
	// Upper slope ends just at full scale
	localparam int COMP_KNEE_X4 = 7399;
	localparam int COMP_BASE_X4 = COMP_KNEE_X4 * COMP_GAIN_X4;

endpackage

`default_nettype wire

// File: design/audio_src_if.sv
////////////////////////////////////////
// Source channel bundle of one sample set
// CD audio, PSG and ADPCM levels
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface audio_src_if;

	// CD audio, stereo
	audio_pkg::sample_t cdda_l;
	audio_pkg::sample_t cdda_r;

	// PSG, stereo
	audio_pkg::sample_t psg_l;
	audio_pkg::sample_t psg_r;

	// ADPCM is mono and feeds both sides
	audio_pkg::sample_t adpcm;

	// Driving side, fed from the top-level ports
	modport src (
		output cdda_l,
		output cdda_r,
		output psg_l,
		output psg_r,
		output adpcm
	);

	// Mixer side, sampled every clock
	modport snk (
		input cdda_l,
		input cdda_r,
		input psg_l,
		input psg_r,
		input adpcm
	);

endinterface

`default_nettype wire

// File: design/audio_level_mix.sv
////////////////////////////////////////
// Three-stage stereo level mixer
// PSG and ADPCM reduction, 18-bit sum,
// CD boost and 5/4 range scaling
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module audio_level_mix (
	input wire clk_sys,
	input wire reset,
	audio_src_if.snk src,
	input wire cd_boost,
	output audio_pkg::sample_t word_l,
	output audio_pkg::sample_t word_r
);

	// Gain of 1/2 + 1/4 + 1/2^last_shift
	function automatic audio_pkg::sample_t reduce(
		audio_pkg::sample_t s,
		int last_shift
	);
		reduce = (s >>> 1) + (s >>> 2) + (s >>> last_shift);
	endfunction

	// Sign extension into the accumulator
	function automatic audio_pkg::wide_t widen(audio_pkg::sample_t s);
		widen = s;
	endfunction

	// Index 0 is left, 1 is right
	audio_pkg::sample_t cdda_in [2];
	audio_pkg::sample_t psg_in [2];

	// Stage 1: reduced sources, CD delayed to stay aligned
	audio_pkg::sample_t cdda_s1 [2];
	audio_pkg::sample_t psg_s1 [2];
	audio_pkg::sample_t adpcm_s1;

	// Stage 2: raw stereo sum
	audio_pkg::wide_t sum_s2 [2];

	// Stage 3: range-scaled sum
	audio_pkg::wide_t mix_s3 [2];

	assign cdda_in = '{src.cdda_l, src.cdda_r};
	assign psg_in = '{src.psg_l, src.psg_r};

	////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			adpcm_s1 <= '0;
			for (int i = 0; i < 2; i++) begin
				cdda_s1[i] <= '0;
				psg_s1[i] <= '0;
				sum_s2[i] <= '0;
				mix_s3[i] <= '0;
			end
		end else begin
			// ADPCM reduction shared by both sides
			adpcm_s1 <= reduce(src.adpcm, 3);

			for (int i = 0; i < 2; i++) begin
				cdda_s1[i] <= cdda_in[i];
				psg_s1[i] <= reduce(psg_in[i], 4);

				// CD counted a second time under boost
				sum_s2[i] <= widen(cdda_s1[i])
					+ (cd_boost ? widen(cdda_s1[i]) : '0)
					+ widen(psg_s1[i])
					+ widen(adpcm_s1);

				// Without boost, 1 + 1/4 to fill the range
				if (cd_boost) begin
					mix_s3[i] <= sum_s2[i];
				end else begin
					mix_s3[i] <= sum_s2[i] + (sum_s2[i] >>> 2);
				end
			end
		end
	end

	// Upper 16 bits of the accumulator
	assign word_l = mix_s3[0][17:2];
	assign word_r = mix_s3[1][17:2];

endmodule

`default_nettype wire

// File: design/audio_compressor.sv
////////////////////////////////////////
// Two-slope compressor for one channel
// 2x and 4x modes, registered output
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module audio_compressor (
	input wire clk_sys,
	input wire reset,
	input wire audio_pkg::sample_t word,
	input wire audio_pkg::boost_t master_boost,
	output audio_pkg::sample_t audio
);

	// Works on the 16-bit magnitude, sign restored at the end
	function automatic audio_pkg::sample_t compress(
		audio_pkg::sample_t w,
		int knee,
		int gain,
		int ratio,
		int base
	);
		logic [15:0] v;
		logic [15:0] m;

		// Magnitude; -32768 reads as 32768 here
		if (w[15]) begin
			v = 16'(-w);
		end else begin
			v = 16'(w);
		end

		// Steep slope below the knee, shallow slope above
		if (v < knee) begin
			m = 16'(v * gain);
		end else begin
			m = 16'((v - knee) / ratio + base);
		end

		if (w[15]) begin
			compress = 16'(-m);
		end else begin
			compress = m;
		end
	endfunction

	audio_pkg::sample_t comp_x2;
	audio_pkg::sample_t comp_x4;
	audio_pkg::sample_t shaped;

	////////////////////////////////////////
	// Slope evaluation per mode
	////////////////////////////////////////

	// Constant knee and ratio keep each path free of a divider
	assign comp_x2 = compress(
		word,
		audio_pkg::COMP_KNEE_X2,
		audio_pkg::COMP_GAIN_X2,
		audio_pkg::COMP_RATIO_X2,
		audio_pkg::COMP_BASE_X2
	);

	assign comp_x4 = compress(
		word,
		audio_pkg::COMP_KNEE_X4,
		audio_pkg::COMP_GAIN_X4,
		audio_pkg::COMP_RATIO_X4,
		audio_pkg::COMP_BASE_X4
	);

	// Mode decode, code 3 falls through to 4x
	always_comb begin
		case (master_boost)
			audio_pkg::BOOST_OFF: begin
				shaped = word;
			end
			audio_pkg::BOOST_X2: begin
				shaped = comp_x2;
			end
			default: begin
				shaped = comp_x4;
			end
		endcase
	end

	////////////////////////////////////////
	// Output register, last pipeline stage
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio <= '0;
		end else begin
			audio <= shaped;
		end
	end

endmodule

`default_nettype wire

// File: design/audio_mixer_top.sv
////////////////////////////////////////
// Audio mixing and loudness path
// Level mixer and two compressors
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module audio_mixer_top (
	input wire clk_sys,
	input wire reset,

	// Source sample set, one per clock
	input wire audio_pkg::sample_t cdda_l,
	input wire audio_pkg::sample_t cdda_r,
	input wire audio_pkg::sample_t psg_l,
	input wire audio_pkg::sample_t psg_r,
	input wire audio_pkg::sample_t adpcm,

	// Loudness controls
	input wire cd_boost,
	input wire audio_pkg::boost_t master_boost,

	// Mixed output, four clocks after its sample set
	output audio_pkg::sample_t audio_l,
	output audio_pkg::sample_t audio_r
);

	audio_src_if src_bus ();

	// Upper words of the stage-3 mix
	wire audio_pkg::sample_t word_l;
	wire audio_pkg::sample_t word_r;

	// Source side of the channel bundle
	assign src_bus.cdda_l = cdda_l;
	assign src_bus.cdda_r = cdda_r;
	assign src_bus.psg_l = psg_l;
	assign src_bus.psg_r = psg_r;
	assign src_bus.adpcm = adpcm;

	////////////////////////////////////////
	// Mixer, stages 1 to 3
	////////////////////////////////////////

	audio_level_mix u_level_mix (
		.clk_sys (clk_sys),
		.reset (reset),
		.src (src_bus.snk),
		.cd_boost (cd_boost),
		.word_l (word_l),
		.word_r (word_r)
	);

	////////////////////////////////////////
	// Compressors, stage 4
	////////////////////////////////////////

	audio_compressor comp_l (
		.clk_sys (clk_sys),
		.reset (reset),
		.word (word_l),
		.master_boost (master_boost),
		.audio (audio_l)
	);

	audio_compressor comp_r (
		.clk_sys (clk_sys),
		.reset (reset),
		.word (word_r),
		.master_boost (master_boost),
		.audio (audio_r)
	);

endmodule

`default_nettype wire

// File: verification/audio_mixer_assert.sv
////////////////////////////////////////
// Concurrent checks on the mixer ports
// Bound into audio_mixer_top
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module audio_mixer_assert (
	input wire clk_sys,
	input wire reset,
	input wire audio_pkg::sample_t cdda_l,
	input wire audio_pkg::sample_t cdda_r,
	input wire audio_pkg::sample_t psg_l,
	input wire audio_pkg::sample_t psg_r,
	input wire audio_pkg::sample_t adpcm,
	input wire cd_boost,
	input wire audio_pkg::boost_t master_boost,
	input wire audio_pkg::sample_t audio_l,
	input wire audio_pkg::sample_t audio_r
);

	// Count of failed assertions
	int assert_errors = 0;

	// Left mix with CD counted twice and no scaling
	function automatic int boosted_sum(
		audio_pkg::sample_t cd,
		audio_pkg::sample_t psg,
		audio_pkg::sample_t ad
	);
		int p;
		int a;
		p = (psg >>> 1) + (psg >>> 2) + (psg >>> 4);
		a = (ad >>> 1) + (ad >>> 2) + (ad >>> 3);
		return 2 * cd + p + a;
	endfunction

	wire all_zero = (cdda_l == '0) && (cdda_r == '0) && (psg_l == '0)
		&& (psg_r == '0) && (adpcm == '0);
	wire sign_mode = cd_boost && (master_boost == audio_pkg::BOOST_OFF) && !reset;
	wire mix_neg_l = boosted_sum(cdda_l, psg_l, adpcm) < 0;

	reset_clears: assert property (@(posedge clk_sys)
		reset |=> (audio_l == '0 && audio_r == '0))
		else begin
			assert_errors++;
			$error("Outputs not cleared one cycle after reset");
		end

	// Silent sources give silence in every mode
	zero_in_zero_out: assert property (@(posedge clk_sys) disable iff (reset)
		($past(all_zero, 1) && $past(all_zero, 2) && $past(all_zero, 3)
			&& $past(all_zero, 4)) |-> (audio_l == '0 && audio_r == '0))
		else begin
			assert_errors++;
			$error("Outputs not zero after four cycles of silent inputs");
		end

	left_sign_follows_mix: assert property (@(posedge clk_sys) disable iff (reset)
		($past(sign_mode, 1) && $past(sign_mode, 2) && $past(sign_mode, 3)
			&& $past(sign_mode, 4)) |-> (audio_l[15] == $past(mix_neg_l, 4)))
		else begin
			assert_errors++;
			$error("Sign of audio_l differs from the boosted left mix");
		end

endmodule

bind audio_mixer_top audio_mixer_assert u_assert (.*);

`default_nettype wire

// File: verification/tb_audio_mixer.sv
////////////////////////////////////////
// Table-driven testbench for the mixer
// Reference model, checker, watchdog
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_audio_mixer;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 10;
	localparam int LAT = audio_pkg::MIX_LATENCY;

	// One stimulus row with its expected outputs
	typedef struct packed {
		logic signed [15:0] cdda_l;
		logic signed [15:0] cdda_r;
		logic signed [15:0] psg_l;
		logic signed [15:0] psg_r;
		logic signed [15:0] adpcm;
		logic cd_boost;
		logic [1:0] mode;
		logic signed [15:0] exp_l;
		logic signed [15:0] exp_r;
	} row_t;

	logic clk_sys;
	logic reset;
	audio_pkg::sample_t cdda_l;
	audio_pkg::sample_t cdda_r;
	audio_pkg::sample_t psg_l;
	audio_pkg::sample_t psg_r;
	audio_pkg::sample_t adpcm;
	logic cd_boost;
	audio_pkg::boost_t master_boost;
	audio_pkg::sample_t audio_l;
	audio_pkg::sample_t audio_r;

	row_t rows[$];
	int errors = 0;
	int checks = 0;
	bit table_ready = 0;
	logic [31:0] rng_state = 32'd19406;

	audio_mixer_top dut (
		.clk_sys (clk_sys),
		.reset (reset),
		.cdda_l (cdda_l),
		.cdda_r (cdda_r),
		.psg_l (psg_l),
		.psg_r (psg_r),
		.adpcm (adpcm),
		.cd_boost (cd_boost),
		.master_boost (master_boost),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic int wrap16(int x);
		logic signed [15:0] t;
		t = x[15:0];
		return int'(t);
	endfunction

	function automatic int wrap18(int x);
		logic signed [17:0] t;
		t = x[17:0];
		return int'(t);
	endfunction

	function automatic int reduce_model(int s, int last_shift);
		return wrap16((s >>> 1) + (s >>> 2) + (s >>> last_shift));
	endfunction

	function automatic int compress_model(int w, logic [1:0] mode);
		int knee;
		int gain;
		int ratio;
		int base;
		int v;
		int m;
		if (mode == 2'd0) begin
			return w;
		end
		if (mode == 2'd1) begin
			knee = audio_pkg::COMP_KNEE_X2;
			gain = audio_pkg::COMP_GAIN_X2;
			ratio = audio_pkg::COMP_RATIO_X2;
		end else begin
			knee = audio_pkg::COMP_KNEE_X4;
			gain = audio_pkg::COMP_GAIN_X4;
			ratio = audio_pkg::COMP_RATIO_X4;
		end
		base = knee * gain;
		v = (w < 0) ? -w : w;
		m = (v < knee) ? v * gain : (v - knee) / ratio + base;
		m = m & 16'hffff;
		return wrap16((w < 0) ? -m : m);
	endfunction

	// One side through sum, optional 5/4 scaling, upper word and compression
	function automatic int expected_side(int cd, int psg, int ad, logic boost,
		logic [1:0] mode);
		int sum;
		int scaled;
		sum = wrap18((boost ? 2 * cd : cd) + reduce_model(psg, 4) + reduce_model(ad, 3));
		scaled = boost ? sum : wrap18(sum + (sum >>> 2));
		return compress_model(wrap16(scaled >>> 2), mode);
	endfunction

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_sample();
		rng_state = xorshift(rng_state);
		return wrap16(rng_state[15:0]);
	endfunction

	////////////////////////////////////////
	// Table construction
	////////////////////////////////////////

	task automatic add_row(int cl, int cr, int pl, int pr, int ad, logic boost,
		logic [1:0] mode);
		row_t r;
		r.cdda_l = 16'(cl);
		r.cdda_r = 16'(cr);
		r.psg_l = 16'(pl);
		r.psg_r = 16'(pr);
		r.adpcm = 16'(ad);
		r.cd_boost = boost;
		r.mode = mode;
		r.exp_l = 16'(expected_side(cl, pl, ad, boost, mode));
		r.exp_r = 16'(expected_side(cr, pr, ad, boost, mode));
		rows.push_back(r);
	endtask

	// Silent rows that flush a group before the controls change
	task automatic close_group(logic boost, logic [1:0] mode);
		for (int i = 0; i < LAT; i++) begin
			add_row(0, 0, 0, 0, 0, boost, mode);
		end
	endtask

	task automatic add_random_group(int count, logic boost, logic [1:0] mode);
		int v [5];
		for (int i = 0; i < count; i++) begin
			for (int c = 0; c < 5; c++) begin
				v[c] = rand_sample();
			end
			add_row(v[0], v[1], v[2], v[3], v[4], boost, mode);
		end
		close_group(boost, mode);
	endtask

	task automatic build_table();
		add_row(0, 0, 0, 0, 0, 1'b0, 2'd0);
		add_row(32767, 32767, 32767, 32767, 32767, 1'b0, 2'd0);
		add_row(-32768, -32768, -32768, -32768, -32768, 1'b0, 2'd0);
		add_row(1234, -4321, 500, -600, 7000, 1'b0, 2'd0);
		close_group(1'b0, 2'd0);
		// CD doubled with independent sides
		add_row(32767, -32768, 32767, -32768, 0, 1'b1, 2'd0);
		add_row(1000, -20000, 300, -300, -50, 1'b1, 2'd0);
		add_row(-1, 1, 0, 0, 0, 1'b1, 2'd0);
		close_group(1'b1, 2'd0);
		// Words 14043, 14044, 14045 and their mirrors
		for (int i = -2; i <= 2; i += 2) begin
			add_row(28088 + i, -(28088 + i), 0, 0, 0, 1'b1, 2'd1);
		end
		add_row(32767, -32768, 32767, -32768, 32767, 1'b1, 2'd1);
		close_group(1'b1, 2'd1);
		// Words around 7399 in 4x mode and in the code 3 alias
		for (int m = 2; m <= 3; m++) begin
			for (int i = -2; i <= 2; i += 2) begin
				add_row(14798 + i, -(14798 + i), 0, 0, 0, 1'b1, 2'(m));
			end
			close_group(1'b1, 2'(m));
		end
		add_row(20000, -20000, 10000, -10000, 0, 1'b0, 2'd1);
		close_group(1'b0, 2'd1);
		for (int g = 0; g < 8; g++) begin
			add_random_group(12, g[0], 2'(g >> 1));
		end
	endtask

	////////////////////////////////////////
	// Driving and checking
	////////////////////////////////////////

	task automatic check_value(string name, audio_pkg::sample_t expected,
		audio_pkg::sample_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %0t %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	task automatic drive_row(row_t r);
		cdda_l = r.cdda_l;
		cdda_r = r.cdda_r;
		psg_l = r.psg_l;
		psg_r = r.psg_r;
		adpcm = r.adpcm;
		cd_boost = r.cd_boost;
		master_boost = audio_pkg::boost_t'(r.mode);
	endtask

	// Row j sees the controls of the next LAT-1 rows while in flight
	function automatic bit stable_controls(int j);
		int idx;
		for (int d = 1; d < LAT; d++) begin
			idx = (j + d > rows.size() - 1) ? rows.size() - 1 : j + d;
			if (rows[idx].cd_boost != rows[j].cd_boost || rows[idx].mode != rows[j].mode) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	initial begin : watchdog
		int limit_ns;
		wait (table_ready);
		limit_ns = 2 * rows.size() * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
		#(limit_ns);
		$display("Timeout: the run did not finish within %0d ns", limit_ns);
		$display("test failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		cdda_l = '0;
		cdda_r = '0;
		psg_l = '0;
		psg_r = '0;
		adpcm = '0;
		cd_boost = 1'b0;
		master_boost = audio_pkg::BOOST_OFF;
		build_table();
		table_ready = 1'b1;

		repeat (RESET_CYCLES) begin
			@(posedge clk_sys);
			#1;
			check_value("audio_l", 0, audio_l);
			check_value("audio_r", 0, audio_r);
		end
		reset = 1'b0;

		// Outputs at step k belong to row k-LAT
		for (int k = 0; k < rows.size() + LAT; k++) begin
			if (k < LAT) begin
				check_value("audio_l", 0, audio_l);
				check_value("audio_r", 0, audio_r);
			end else if (stable_controls(k - LAT)) begin
				check_value("audio_l", rows[k - LAT].exp_l, audio_l);
				check_value("audio_r", rows[k - LAT].exp_r, audio_r);
			end
			if (k < rows.size()) begin
				drive_row(rows[k]);
			end
			@(posedge clk_sys);
			#1;
		end

		$display("Checks: %0d, errors: %0d, assertion errors: %0d",
			checks, errors, dut.u_assert.assert_errors);
		if (errors == 0 && dut.u_assert.assert_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
design/audio_pkg.sv
design/audio_src_if.sv
design/audio_level_mix.sv
design/audio_compressor.sv
design/audio_mixer_top.sv
verification/audio_mixer_assert.sv
verification/tb_audio_mixer.sv
